/* cdr_params.svh */
`ifndef CDR_PARAMS_SVH
`define CDR_PARAMS_SVH

// lane count and sample widths
`define NTI         16
`define NADC        8

// phase interpolator control
`define NPI         9
`define NOUT        4
`define NMAXSEL     5

// cycles from reset release until the pi codes are trusted
`define VALID_WAIT  32

// bit error counters and pattern order
`define CNT_W       32
`define PRBS_ORDER  7

`endif

/* cdr_pkg.sv */
package cdr_pkg;

    //////////////////////////////////////////////////////////////////////
    // receive word source
    //////////////////////////////////////////////////////////////////////

    // encoding 2'd3 is not used
    typedef enum logic [1:0] {
        SRC_ADC  = 2'd0,
        SRC_FFE  = 2'd1,
        SRC_BIST = 2'd2
    } rx_source_e;

    //////////////////////////////////////////////////////////////////////
    // prbs checker state
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        CHK_PRIME = 1'b0,
        CHK_RUN   = 1'b1
    } chk_state_e;

endpackage

/* compile.f */
+incdir+.
cdr_pkg.sv
rx_bit_select.sv
prbs_self_check.sv
err_accumulator.sv
pi_ctl_wrap.sv
digital_core.sv
tb_checker.sv
tb_digital_core.sv

/* digital_core.sv */
`timescale 1ns/1ps
`include "cdr_params.svh"

module digital_core (
    input  logic                    clk_adc,
    input  logic                    cdr_rstb,
    input  logic signed [`NADC-1:0] adc_code_i [`NTI-1:0],
    input  logic signed [`NADC-1:0] adc_thresh_i,
    input  logic [`NTI-1:0]         ffe_bits_i,
    input  cdr_pkg::rx_source_e     rx_source_i,
    input  logic                    bist_en_i,
    input  logic                    inj_err_i,
    input  logic                    cnt_en_i,
    input  logic [`NPI-1:0]         pi_code_i [`NOUT-1:0],
    input  logic [`NMAXSEL-1:0]     max_sel_i [`NOUT-1:0],
    input  logic                    en_ext_scale_i,
    input  logic [`NPI-1:0]         ext_scale_i [`NOUT-1:0],
    input  logic [`NPI-1:0]         pi_offset_i [`NOUT-1:0],
    output logic [`CNT_W-1:0]       err_count_o,
    output logic [`CNT_W-1:0]       total_count_o,
    output logic [`NPI-1:0]         pi_ctl_o [`NOUT-1:0],
    output logic                    ctl_valid_o
);

    // decode to execute
    logic [`NTI-1:0] rx_bits;
    logic            rx_valid;
    logic            src_change;

    // execute to result
    logic [`NTI-1:0] err_flags;
    logic            chk_valid;

    rx_bit_select u_rx_bit_select (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .adc_code_i   (adc_code_i),
        .adc_thresh_i (adc_thresh_i),
        .ffe_bits_i   (ffe_bits_i),
        .rx_source_i  (rx_source_i),
        .bist_en_i    (bist_en_i),
        .inj_err_i    (inj_err_i),
        .rx_bits_o    (rx_bits),
        .rx_valid_o   (rx_valid),
        .src_change_o (src_change)
    );

    prbs_self_check u_prbs_self_check (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .rx_bits_i    (rx_bits),
        .rx_valid_i   (rx_valid),
        .src_change_i (src_change),
        .err_flags_o  (err_flags),
        .chk_valid_o  (chk_valid)
    );

    err_accumulator u_err_accumulator (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .err_flags_i   (err_flags),
        .chk_valid_i   (chk_valid),
        .cnt_en_i      (cnt_en_i),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

    // phase control path, independent of the bit path
    pi_ctl_wrap u_pi_ctl_wrap (
        .clk_adc        (clk_adc),
        .cdr_rstb       (cdr_rstb),
        .pi_code_i      (pi_code_i),
        .max_sel_i      (max_sel_i),
        .en_ext_scale_i (en_ext_scale_i),
        .ext_scale_i    (ext_scale_i),
        .pi_offset_i    (pi_offset_i),
        .pi_ctl_o       (pi_ctl_o),
        .ctl_valid_o    (ctl_valid_o)
    );

endmodule

/* err_accumulator.sv */
`timescale 1ns/1ps
`include "cdr_params.svh"

module err_accumulator (
    input  logic              clk_adc,
    input  logic              cdr_rstb,
    input  logic [`NTI-1:0]   err_flags_i,
    input  logic              chk_valid_i,
    input  logic              cnt_en_i,
    output logic [`CNT_W-1:0] err_count_o,
    output logic [`CNT_W-1:0] total_count_o
);

    localparam int PW = $clog2(`NTI + 1);

    logic [PW-1:0]     err_pop;
    logic [`CNT_W:0]   err_sum;
    logic [`CNT_W:0]   total_sum;

    always_comb begin
        err_pop = '0;
        for (int k = 0; k < `NTI; k++) begin
            err_pop = err_pop + PW'(err_flags_i[k]);
        end
    end

    // one spare bit catches the carry for saturation
    assign err_sum   = {1'b0, err_count_o} + (`CNT_W+1)'(err_pop);
    assign total_sum = {1'b0, total_count_o} + (`CNT_W+1)'(`NTI);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            err_count_o   <= '0;
            total_count_o <= '0;
        end else if (cnt_en_i && chk_valid_i) begin
            err_count_o   <= err_sum[`CNT_W] ? '1 : err_sum[`CNT_W-1:0];
            total_count_o <= total_sum[`CNT_W] ? '1 : total_sum[`CNT_W-1:0];
        end
    end

    err_le_total_a: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        err_count_o <= total_count_o);

endmodule

/* pi_ctl_wrap.sv */
`timescale 1ns/1ps
`include "cdr_params.svh"

module pi_ctl_wrap (
    input  logic               clk_adc,
    input  logic               cdr_rstb,
    input  logic [`NPI-1:0]     pi_code_i [`NOUT-1:0],
    input  logic [`NMAXSEL-1:0] max_sel_i [`NOUT-1:0],
    input  logic               en_ext_scale_i,
    input  logic [`NPI-1:0]     ext_scale_i [`NOUT-1:0],
    input  logic [`NPI-1:0]     pi_offset_i [`NOUT-1:0],
    output logic [`NPI-1:0]     pi_ctl_o [`NOUT-1:0],
    output logic               ctl_valid_o
);

    localparam int WW = $clog2(`VALID_WAIT);

    logic [WW-1:0]  wait_cnt_q;
    logic [`NPI-1:0] scale [`NOUT-1:0];
    logic [`NPI-1:0] wrapped [`NOUT-1:0];

    //////////////////////////////////////////////////////////////////////
    // reset wait
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_cnt_q  <= '0;
            ctl_valid_o <= 1'b0;
        end else begin
            if (wait_cnt_q != WW'(`VALID_WAIT - 1)) begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end
            // goes high one edge after the count tops out
            ctl_valid_o <= (wait_cnt_q == WW'(`VALID_WAIT - 1));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // modulo and offset per output
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < `NOUT; j++) begin
            // (max_sel + 1) * 16 - 1 is max_sel followed by four ones
            scale[j] = en_ext_scale_i ? ext_scale_i[j] : `NPI'({max_sel_i[j], 4'hf});
            // zero scale passes the code through unwrapped
            if (scale[j] == '0) begin
                wrapped[j] = pi_code_i[j] + pi_offset_i[j];
            end else begin
                wrapped[j] = (pi_code_i[j] % scale[j]) + pi_offset_i[j];
            end
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            for (int j = 0; j < `NOUT; j++) begin
                pi_ctl_o[j] <= '0;
            end
        end else begin
            pi_ctl_o <= wrapped;
        end
    end

    valid_sticky_a: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        ctl_valid_o |=> ctl_valid_o);

endmodule

/* prbs_self_check.sv */
`timescale 1ns/1ps
`include "cdr_params.svh"

module prbs_self_check (
    input  logic            clk_adc,
    input  logic            cdr_rstb,
    input  logic [`NTI-1:0] rx_bits_i,
    input  logic            rx_valid_i,
    input  logic            src_change_i,
    output logic [`NTI-1:0] err_flags_o,
    output logic            chk_valid_o
);

    localparam int HW = `PRBS_ORDER;

    logic [HW-1:0]       hist_q;
    logic [`NTI+HW-1:0]  stream;
    logic [`NTI-1:0]     mismatch;
    logic                prime_now;
    cdr_pkg::chk_state_e state_q;

    // history below, current word above, oldest bit at index 0
    assign stream = {rx_bits_i, hist_q};

    // lane k sits at stream[k+HW], taps at 7 and 6 back
    always_comb begin
        for (int k = 0; k < `NTI; k++) begin
            mismatch[k] = rx_bits_i[k] ^ stream[k] ^ stream[k+1];
        end
    end

    assign prime_now = (state_q == cdr_pkg::CHK_PRIME) || src_change_i;

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q     <= cdr_pkg::CHK_PRIME;
            hist_q      <= '0;
            chk_valid_o <= 1'b0;
        end else if (rx_valid_i) begin
            // every valid word refreshes the history
            hist_q      <= rx_bits_i[`NTI-1 -: HW];
            state_q     <= cdr_pkg::CHK_RUN;
            chk_valid_o <= !prime_now;
        end else begin
            chk_valid_o <= 1'b0;
            if (src_change_i) begin
                state_q <= cdr_pkg::CHK_PRIME;
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        err_flags_o <= mismatch;
    end

    // the word that announces a new source must only prime
    prime_after_change_a: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        src_change_i |=> !chk_valid_o);

endmodule

/* rx_bit_select.sv */
`timescale 1ns/1ps
`include "cdr_params.svh"

module rx_bit_select (
    input  logic                    clk_adc,
    input  logic                    cdr_rstb,
    input  logic signed [`NADC-1:0] adc_code_i [`NTI-1:0],
    input  logic signed [`NADC-1:0] adc_thresh_i,
    input  logic [`NTI-1:0]         ffe_bits_i,
    input  cdr_pkg::rx_source_e     rx_source_i,
    input  logic                    bist_en_i,
    input  logic                    inj_err_i,
    output logic [`NTI-1:0]         rx_bits_o,
    output logic                    rx_valid_o,
    output logic                    src_change_o
);

    logic [`NTI-1:0]        sliced_bits;
    logic [`NTI-1:0]        bist_word;
    logic [`NTI-1:0]        rx_word;
    logic [`PRBS_ORDER-1:0] lfsr_q;
    logic [`PRBS_ORDER-1:0] lfsr_next;
    logic                   new_bit;
    cdr_pkg::rx_source_e    src_prev_q;

    // one comparator per lane, signed compare
    always_comb begin
        for (int k = 0; k < `NTI; k++) begin
            sliced_bits[k] = (adc_code_i[k] > adc_thresh_i);
        end
    end

    // bist generator, x^7+x^6+1
    // lfsr[0] is the bit 7 back, lfsr[1] the bit 6 back
    always_comb begin
        lfsr_next = lfsr_q;
        for (int k = 0; k < `NTI; k++) begin
            new_bit      = lfsr_next[0] ^ lfsr_next[1];
            bist_word[k] = new_bit;
            lfsr_next    = {new_bit, lfsr_next[`PRBS_ORDER-1:1]};
        end
        // single error lands on the oldest lane only
        bist_word[0] = bist_word[0] ^ inj_err_i;
    end

    always_comb begin
        case (rx_source_i)
            cdr_pkg::SRC_FFE:  rx_word = ffe_bits_i;
            cdr_pkg::SRC_BIST: rx_word = bist_word;
            default:           rx_word = sliced_bits;
        endcase
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            lfsr_q       <= '1;
            rx_valid_o   <= 1'b0;
            src_change_o <= 1'b0;
            src_prev_q   <= cdr_pkg::SRC_ADC;
        end else begin
            if (bist_en_i) begin
                lfsr_q <= lfsr_next;
            end
            // a stalled generator repeats its word, so no valid then
            rx_valid_o   <= (rx_source_i != cdr_pkg::SRC_BIST) || bist_en_i;
            src_change_o <= (rx_source_i != src_prev_q);
            src_prev_q   <= rx_source_i;
        end
    end

    always_ff @(posedge clk_adc) begin
        rx_bits_o <= rx_word;
    end

    source_legal_a: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        rx_source_i inside {cdr_pkg::SRC_ADC, cdr_pkg::SRC_FFE, cdr_pkg::SRC_BIST});

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps
`include "cdr_params.svh"

module tb_checker (
    input  logic               clk_adc,
    input  logic               cdr_rstb,
    input  logic [`NPI-1:0]     pi_code_i [`NOUT-1:0],
    input  logic [`NMAXSEL-1:0] max_sel_i [`NOUT-1:0],
    input  logic               en_ext_scale_i,
    input  logic [`NPI-1:0]     ext_scale_i [`NOUT-1:0],
    input  logic [`NPI-1:0]     pi_offset_i [`NOUT-1:0],
    input  logic [`NPI-1:0]     pi_ctl_i [`NOUT-1:0],
    input  logic               ctl_valid_i,
    input  logic [`CNT_W-1:0]   err_count_i,
    input  logic [`CNT_W-1:0]   total_count_i,
    input  logic               mark_i,
    input  int                 exp_err_i,
    input  int                 exp_tot_i,
    output int                 errors_o,
    output int                 checks_o
);

    logic [2:0]        mark_d;
    int                err_d [3];
    int                tot_d [3];
    logic [`CNT_W-1:0] err_base;
    logic [`CNT_W-1:0] tot_base;
    logic [`NPI-1:0]   pi_exp [`NOUT-1:0];
    logic              pi_armed;
    int                edges;
    int                sc;

    initial begin
        errors_o = 0;
        checks_o = 0;
    end

    // four state arguments so an unknown output never compares equal
    task automatic check_value(input string name, input logic [63:0] expv,
                               input logic [63:0] gotv);
        checks_o++;
        if (expv !== gotv) begin
            errors_o++;
            $display("ERR t=%0t %s expected=%0d actual=%0d", $time, name, expv, gotv);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // counter deltas, three edges after the marked word
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            mark_d   <= '0;
            err_base <= '0;
            tot_base <= '0;
            edges    <= 0;
        end else begin
            if (mark_d[2]) begin
                check_value("err_count_o", err_d[2], err_count_i - err_base);
                check_value("total_count_o", tot_d[2], total_count_i - tot_base);
                err_base <= err_count_i;
                tot_base <= total_count_i;
            end
            mark_d   <= {mark_d[1:0], mark_i};
            err_d[2] <= err_d[1];
            err_d[1] <= err_d[0];
            err_d[0] <= exp_err_i;
            tot_d[2] <= tot_d[1];
            tot_d[1] <= tot_d[0];
            tot_d[0] <= exp_tot_i;
            edges    <= edges + 1;
        end
    end

    // pi output follows its inputs by one edge
    always @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            pi_armed <= 1'b0;
        end else begin
            for (int j = 0; j < `NOUT; j++) begin
                if (pi_armed) begin
                    check_value($sformatf("pi_ctl_o[%0d]", j), pi_exp[j], pi_ctl_i[j]);
                end
                sc = en_ext_scale_i ? int'(ext_scale_i[j]) : (int'(max_sel_i[j]) + 1) * 16 - 1;
                pi_exp[j] = `NPI'((int'(pi_code_i[j]) % sc) + int'(pi_offset_i[j]));
            end
            pi_armed <= 1'b1;
        end
    end

    always @(negedge clk_adc) begin
        if (cdr_rstb) begin
            check_value("ctl_valid_o", edges >= `VALID_WAIT, ctl_valid_i);
        end
    end

endmodule

/* tb_digital_core.sv */
`timescale 1ns/1ps
`include "cdr_params.svh"

module tb_digital_core;

    localparam int NENT = 7;

    // one column per field, one entry per index
    // 0 bist prime, 1 bist inject, 2 adc clean, 3 adc high threshold,
    // 4 ffe flips, 5 ffe counting off, 6 bist after source change
    int t_src [NENT]   = '{2, 2, 0, 0, 1, 1, 2};
    int t_thr [NENT]   = '{0, 0, 0, 127, 0, 0, 0};
    int t_words [NENT] = '{6, 8, 6, 4, 8, 5, 5};
    int t_inj [NENT]   = '{0, 2, 0, 0, 2, 1, 1};
    int t_ext [NENT]   = '{0, 1, 0, 1, 0, 1, 0};
    int t_cnt [NENT]   = '{1, 1, 1, 1, 1, 0, 1};
    // -1 leaves the error increment to the reference model
    int t_err [NENT]   = '{0, 6, 0, -1, 6, 0, 3};
    int t_tot [NENT]   = '{80, 128, 80, 64, 112, 0, 64};

    logic                    clk_adc;
    logic                    cdr_rstb;
    logic signed [`NADC-1:0] adc_code [`NTI-1:0];
    logic signed [`NADC-1:0] adc_thresh;
    logic [`NTI-1:0]         ffe_bits;
    cdr_pkg::rx_source_e     rx_source;
    logic                    bist_en;
    logic                    inj_err;
    logic                    cnt_en;
    logic                    en_ext_scale;
    logic [`NPI-1:0]         pi_code [`NOUT-1:0];
    logic [`NMAXSEL-1:0]     max_sel [`NOUT-1:0];
    logic [`NPI-1:0]         ext_scale [`NOUT-1:0];
    logic [`NPI-1:0]         pi_offset [`NOUT-1:0];
    logic [`CNT_W-1:0]       err_count;
    logic [`CNT_W-1:0]       total_count;
    logic [`NPI-1:0]         pi_ctl [`NOUT-1:0];
    logic                    ctl_valid;
    logic                    mark;
    int                      exp_err;
    int                      exp_tot;
    int                      errors;
    int                      checks;
    int                      cycles;
    int                      limit;
    int                      ent_err;
    logic [31:0]             rng;
    // reference histories, [0] newest and [6] seven bits back
    logic [6:0]              bist_h;
    logic [6:0]              pat_h;
    logic [6:0]              rx_h;
    logic                    need_prime;
    cdr_pkg::rx_source_e     prev_src;
    logic                    cnt_d1;
    logic                    cnt_d2;

    digital_core DUT (
        .clk_adc        (clk_adc),
        .cdr_rstb       (cdr_rstb),
        .adc_code_i     (adc_code),
        .adc_thresh_i   (adc_thresh),
        .ffe_bits_i     (ffe_bits),
        .rx_source_i    (rx_source),
        .bist_en_i      (bist_en),
        .inj_err_i      (inj_err),
        .cnt_en_i       (cnt_en),
        .pi_code_i      (pi_code),
        .max_sel_i      (max_sel),
        .en_ext_scale_i (en_ext_scale),
        .ext_scale_i    (ext_scale),
        .pi_offset_i    (pi_offset),
        .err_count_o    (err_count),
        .total_count_o  (total_count),
        .pi_ctl_o       (pi_ctl),
        .ctl_valid_o    (ctl_valid)
    );

    tb_checker u_checker (
        .clk_adc        (clk_adc),
        .cdr_rstb       (cdr_rstb),
        .pi_code_i      (pi_code),
        .max_sel_i      (max_sel),
        .en_ext_scale_i (en_ext_scale),
        .ext_scale_i    (ext_scale),
        .pi_offset_i    (pi_offset),
        .pi_ctl_i       (pi_ctl),
        .ctl_valid_i    (ctl_valid),
        .err_count_i    (err_count),
        .total_count_i  (total_count),
        .mark_i         (mark),
        .exp_err_i      (exp_err),
        .exp_tot_i      (exp_tot),
        .errors_o       (errors),
        .checks_o       (checks)
    );

    function automatic logic [6:0] prbs_shift(input logic [6:0] h);
        return {h[5:0], h[5] ^ h[6]};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // counter enable lags its word by the two stages in front of the counters
    task automatic push_cnt(input logic c);
        cnt_en = cnt_d2;
        cnt_d2 = cnt_d1;
        cnt_d1 = c;
    endtask

    task automatic drive_word(input int e, input int w);
        logic [`NTI-1:0] bits;
        logic            flip;
        logic            counted;
        int              mag;
        flip         = (w > 0) && (w % 2 == 0) && (w / 2 <= t_inj[e]);
        rx_source    = cdr_pkg::rx_source_e'(t_src[e]);
        adc_thresh   = t_thr[e];
        bist_en      = (t_src[e] == 2);
        inj_err      = flip && (t_src[e] == 2);
        en_ext_scale = t_ext[e];
        for (int k = 0; k < `NTI; k++) begin
            if (t_src[e] == 2) begin
                bist_h  = prbs_shift(bist_h);
                bits[k] = bist_h[0] ^ (inj_err && k == 0);
            end else begin
                pat_h       = prbs_shift(pat_h);
                rng         = xorshift(rng);
                mag         = 1 + int'(rng[15:0] % 100);
                adc_code[k] = pat_h[0] ? mag : -mag;
                ffe_bits[k] = pat_h[0] ^ (flip && k == 3);
                bits[k]     = (t_src[e] == 1) ? ffe_bits[k] : (adc_code[k] > adc_thresh);
            end
        end
        // first word of a new source only loads history
        if (rx_source != prev_src) begin
            need_prime = 1'b1;
        end
        counted    = !need_prime && t_cnt[e];
        need_prime = 1'b0;
        prev_src   = rx_source;
        for (int k = 0; k < `NTI; k++) begin
            if (counted && (bits[k] ^ rx_h[5] ^ rx_h[6])) begin
                ent_err++;
            end
            rx_h = {rx_h[5:0], bits[k]};
        end
        for (int j = 0; j < `NOUT; j++) begin
            rng          = xorshift(rng);
            pi_code[j]   = rng[8:0];
            max_sel[j]   = rng[13:9];
            ext_scale[j] = rng[22:14] | 9'd1;
            pi_offset[j] = rng[31:23];
        end
        mark    = (w == t_words[e] - 1);
        exp_err = (t_err[e] >= 0) ? t_err[e] : ent_err;
        exp_tot = t_tot[e];
        push_cnt(t_cnt[e]);
    endtask

    always #50 clk_adc = ~clk_adc;

    always @(posedge clk_adc) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: stimulus did not finish within %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        clk_adc      = 1'b0;
        cdr_rstb     = 1'b0;
        adc_thresh   = '0;
        ffe_bits     = '0;
        rx_source    = cdr_pkg::SRC_ADC;
        bist_en      = 1'b0;
        inj_err      = 1'b0;
        cnt_en       = 1'b0;
        en_ext_scale = 1'b0;
        mark         = 1'b0;
        exp_err      = 0;
        exp_tot      = 0;
        for (int k = 0; k < `NTI; k++) begin
            adc_code[k] = '0;
        end
        for (int j = 0; j < `NOUT; j++) begin
            pi_code[j]   = '0;
            max_sel[j]   = '0;
            ext_scale[j] = 9'd1;
            pi_offset[j] = '0;
        end
        rng        = 32'h6fec;
        bist_h     = '1;
        pat_h      = '1;
        rx_h       = '0;
        need_prime = 1'b1;
        prev_src   = cdr_pkg::SRC_ADC;
        cnt_d1     = 1'b0;
        cnt_d2     = 1'b0;
        cycles     = 0;
        limit      = 64 + 5 + 8;
        for (int e = 0; e < NENT; e++) begin
            limit += t_words[e];
        end
        repeat (5) @(negedge clk_adc);
        cdr_rstb = 1'b1;
        for (int e = 0; e < NENT; e++) begin
            ent_err = 0;
            for (int w = 0; w < t_words[e]; w++) begin
                drive_word(e, w);
                @(negedge clk_adc);
            end
        end
        // drain the pipeline so the last entry reaches the counters
        mark = 1'b0;
        repeat (8) begin
            push_cnt(1'b0);
            @(negedge clk_adc);
        end
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
